// File: design/tlb_pkg.sv
package tlb_pkg;

    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = $clog2(TLB_NUM);

    // index and per-entry bit vector
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;
    typedef logic [TLB_NUM-1:0]   tlb_vec_t;

    // entry field widths
    typedef logic [18:0] vppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [4:0]  invtlb_op_t;

    // page size codes as log2 of the page bytes
    localparam ps_t PS_4K = 6'd12;
    localparam ps_t PS_2M = 6'd21;

    // invtlb operation codes
    localparam invtlb_op_t INV_ALL0         = 5'd0;
    localparam invtlb_op_t INV_ALL1         = 5'd1;
    localparam invtlb_op_t INV_G1           = 5'd2;
    localparam invtlb_op_t INV_G0           = 5'd3;
    localparam invtlb_op_t INV_G0_ASID      = 5'd4;
    localparam invtlb_op_t INV_G0_ASID_VA   = 5'd5;
    localparam invtlb_op_t INV_G_OR_ASID_VA = 5'd6;

endpackage

// File: design/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array (
    input  logic               clk,
    input  logic               arst_n,
    // write port
    input  logic               we,
    input  tlb_pkg::tlb_idx_t  w_index,
    input  logic               w_e,
    input  tlb_pkg::vppn_t     w_vppn,
    input  tlb_pkg::ps_t       w_ps,
    input  tlb_pkg::asid_t     w_asid,
    input  logic               w_g,
    input  tlb_pkg::ppn_t      w_ppn0,
    input  tlb_pkg::plv_t      w_plv0,
    input  tlb_pkg::mat_t      w_mat0,
    input  logic               w_d0,
    input  logic               w_v0,
    input  tlb_pkg::ppn_t      w_ppn1,
    input  tlb_pkg::plv_t      w_plv1,
    input  tlb_pkg::mat_t      w_mat1,
    input  logic               w_d1,
    input  logic               w_v1,
    // invalidate
    input  tlb_pkg::tlb_vec_t  clear_vec,
    // read port
    input  tlb_pkg::tlb_idx_t  r_index,
    output logic               r_e,
    output tlb_pkg::vppn_t     r_vppn,
    output tlb_pkg::ps_t       r_ps,
    output tlb_pkg::asid_t     r_asid,
    output logic               r_g,
    output tlb_pkg::ppn_t      r_ppn0,
    output tlb_pkg::plv_t      r_plv0,
    output tlb_pkg::mat_t      r_mat0,
    output logic               r_d0,
    output logic               r_v0,
    output tlb_pkg::ppn_t      r_ppn1,
    output tlb_pkg::plv_t      r_plv1,
    output tlb_pkg::mat_t      r_mat1,
    output logic               r_d1,
    output logic               r_v1,
    // stored entries
    output tlb_pkg::tlb_vec_t  ent_e,
    output tlb_pkg::tlb_vec_t  ent_g,
    output tlb_pkg::vppn_t     ent_vppn [tlb_pkg::TLB_NUM],
    output tlb_pkg::ps_t       ent_ps   [tlb_pkg::TLB_NUM],
    output tlb_pkg::asid_t     ent_asid [tlb_pkg::TLB_NUM],
    output tlb_pkg::ppn_t      ent_ppn0 [tlb_pkg::TLB_NUM],
    output tlb_pkg::plv_t      ent_plv0 [tlb_pkg::TLB_NUM],
    output tlb_pkg::mat_t      ent_mat0 [tlb_pkg::TLB_NUM],
    output tlb_pkg::tlb_vec_t  ent_d0,
    output tlb_pkg::tlb_vec_t  ent_v0,
    output tlb_pkg::ppn_t      ent_ppn1 [tlb_pkg::TLB_NUM],
    output tlb_pkg::plv_t      ent_plv1 [tlb_pkg::TLB_NUM],
    output tlb_pkg::mat_t      ent_mat1 [tlb_pkg::TLB_NUM],
    output tlb_pkg::tlb_vec_t  ent_d1,
    output tlb_pkg::tlb_vec_t  ent_v1
);
    import tlb_pkg::*;

    // a write wins over a clear on the same entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_e <= '0;
        end else begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (we && w_index == tlb_idx_t'(i)) begin
                    ent_e[i] <= w_e;
                end else if (clear_vec[i]) begin
                    ent_e[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ent_vppn[w_index] <= w_vppn;
            ent_ps[w_index]   <= w_ps;
            ent_asid[w_index] <= w_asid;
            ent_g[w_index]    <= w_g;
            ent_ppn0[w_index] <= w_ppn0;
            ent_plv0[w_index] <= w_plv0;
            ent_mat0[w_index] <= w_mat0;
            ent_d0[w_index]   <= w_d0;
            ent_v0[w_index]   <= w_v0;
            ent_ppn1[w_index] <= w_ppn1;
            ent_plv1[w_index] <= w_plv1;
            ent_mat1[w_index] <= w_mat1;
            ent_d1[w_index]   <= w_d1;
            ent_v1[w_index]   <= w_v1;
        end
    end

    assign r_e    = ent_e[r_index];
    assign r_vppn = ent_vppn[r_index];
    assign r_ps   = ent_ps[r_index];
    assign r_asid = ent_asid[r_index];
    assign r_g    = ent_g[r_index];
    assign r_ppn0 = ent_ppn0[r_index];
    assign r_plv0 = ent_plv0[r_index];
    assign r_mat0 = ent_mat0[r_index];
    assign r_d0   = ent_d0[r_index];
    assign r_v0   = ent_v0[r_index];
    assign r_ppn1 = ent_ppn1[r_index];
    assign r_plv1 = ent_plv1[r_index];
    assign r_mat1 = ent_mat1[r_index];
    assign r_d1   = ent_d1[r_index];
    assign r_v1   = ent_v1[r_index];

endmodule

// File: design/tlb_match.sv
`timescale 1ns/1ps

module tlb_match (
    input  tlb_pkg::vppn_t     s_vppn,
    input  tlb_pkg::asid_t     s_asid,
    input  tlb_pkg::tlb_vec_t  ent_e,
    input  tlb_pkg::tlb_vec_t  ent_g,
    input  tlb_pkg::vppn_t     ent_vppn [tlb_pkg::TLB_NUM],
    input  tlb_pkg::ps_t       ent_ps   [tlb_pkg::TLB_NUM],
    input  tlb_pkg::asid_t     ent_asid [tlb_pkg::TLB_NUM],
    output tlb_pkg::tlb_vec_t  hit_vec,
    output tlb_pkg::tlb_vec_t  asid_vec,
    output tlb_pkg::tlb_vec_t  va_vec
);
    import tlb_pkg::*;

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_ent
        logic is_2m;
        logic hi_eq;
        logic lo_eq;

        assign is_2m = (ent_ps[i] == PS_2M);

        // a 2 MB page spans the whole low part of the vppn
        assign hi_eq = (s_vppn[18:9] == ent_vppn[i][18:9]);
        assign lo_eq = is_2m || (s_vppn[8:0] == ent_vppn[i][8:0]);

        assign asid_vec[i] = (s_asid == ent_asid[i]);
        assign va_vec[i]   = ent_e[i] && hi_eq && lo_eq;
        assign hit_vec[i]  = va_vec[i] && (ent_g[i] || asid_vec[i]);
    end

endmodule

// File: design/invtlb_decode.sv
`timescale 1ns/1ps

module invtlb_decode (
    input  logic                 invtlb_valid,
    input  tlb_pkg::invtlb_op_t  invtlb_op,
    input  tlb_pkg::tlb_vec_t    ent_g,
    input  tlb_pkg::tlb_vec_t    asid_vec,
    input  tlb_pkg::tlb_vec_t    va_vec,
    output tlb_pkg::tlb_vec_t    clear_vec
);
    import tlb_pkg::*;

    always_comb begin
        clear_vec = '0;
        if (invtlb_valid) begin
            case (invtlb_op)
                INV_ALL0, INV_ALL1: begin
                    clear_vec = '1;
                end
                INV_G1: begin
                    clear_vec = ent_g;
                end
                INV_G0: begin
                    clear_vec = ~ent_g;
                end
                INV_G0_ASID: begin
                    clear_vec = ~ent_g & asid_vec;
                end
                INV_G0_ASID_VA: begin
                    clear_vec = ~ent_g & asid_vec & va_vec;
                end
                INV_G_OR_ASID_VA: begin
                    clear_vec = (ent_g | asid_vec) & va_vec;
                end
                // reserved codes leave the entries alone
                default: begin
                    clear_vec = '0;
                end
            endcase
        end
    end

endmodule

// File: design/tlb_search_result.sv
`timescale 1ns/1ps

module tlb_search_result (
    input  tlb_pkg::tlb_vec_t  hit_vec,
    input  tlb_pkg::vppn_t     s_vppn,
    input  logic               s_va_bit12,
    input  tlb_pkg::ps_t       ent_ps   [tlb_pkg::TLB_NUM],
    input  tlb_pkg::ppn_t      ent_ppn0 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::plv_t      ent_plv0 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::mat_t      ent_mat0 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::tlb_vec_t  ent_d0,
    input  tlb_pkg::tlb_vec_t  ent_v0,
    input  tlb_pkg::ppn_t      ent_ppn1 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::plv_t      ent_plv1 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::mat_t      ent_mat1 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::tlb_vec_t  ent_d1,
    input  tlb_pkg::tlb_vec_t  ent_v1,
    output logic               s_found,
    output tlb_pkg::tlb_idx_t  s_index,
    output tlb_pkg::ppn_t      s_ppn,
    output tlb_pkg::ps_t       s_ps,
    output tlb_pkg::plv_t      s_plv,
    output tlb_pkg::mat_t      s_mat,
    output logic               s_d,
    output logic               s_v
);
    import tlb_pkg::*;

    tlb_idx_t hit_idx;
    logic     odd;

    // scan downwards so the lowest hitting index is left in hit_idx
    always_comb begin
        s_found = 1'b0;
        hit_idx = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                s_found = 1'b1;
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    // odd page bit is va[12] for 4 KB, va[21] (vppn bit 8) for 2 MB
    assign odd = (ent_ps[hit_idx] == PS_2M) ? s_vppn[8] : s_va_bit12;

    assign s_index = hit_idx;
    assign s_ps    = ent_ps[hit_idx];
    assign s_ppn   = odd ? ent_ppn1[hit_idx] : ent_ppn0[hit_idx];
    assign s_plv   = odd ? ent_plv1[hit_idx] : ent_plv0[hit_idx];
    assign s_mat   = odd ? ent_mat1[hit_idx] : ent_mat0[hit_idx];
    assign s_d     = odd ? ent_d1[hit_idx]   : ent_d0[hit_idx];
    assign s_v     = odd ? ent_v1[hit_idx]   : ent_v0[hit_idx];

endmodule

// File: design/tlb_top.sv
`timescale 1ns/1ps

module tlb_top (
    input  logic                 clk,
    input  logic                 arst_n,
    // search port
    input  tlb_pkg::vppn_t       s_vppn,
    input  logic                 s_va_bit12,
    input  tlb_pkg::asid_t       s_asid,
    output logic                 s_found,
    output tlb_pkg::tlb_idx_t    s_index,
    output tlb_pkg::ppn_t        s_ppn,
    output tlb_pkg::ps_t         s_ps,
    output tlb_pkg::plv_t        s_plv,
    output tlb_pkg::mat_t        s_mat,
    output logic                 s_d,
    output logic                 s_v,
    // invtlb
    input  logic                 invtlb_valid,
    input  tlb_pkg::invtlb_op_t  invtlb_op,
    // write port
    input  logic                 we,
    input  tlb_pkg::tlb_idx_t    w_index,
    input  logic                 w_e,
    input  tlb_pkg::vppn_t       w_vppn,
    input  tlb_pkg::ps_t         w_ps,
    input  tlb_pkg::asid_t       w_asid,
    input  logic                 w_g,
    input  tlb_pkg::ppn_t        w_ppn0,
    input  tlb_pkg::plv_t        w_plv0,
    input  tlb_pkg::mat_t        w_mat0,
    input  logic                 w_d0,
    input  logic                 w_v0,
    input  tlb_pkg::ppn_t        w_ppn1,
    input  tlb_pkg::plv_t        w_plv1,
    input  tlb_pkg::mat_t        w_mat1,
    input  logic                 w_d1,
    input  logic                 w_v1,
    // read port
    input  tlb_pkg::tlb_idx_t    r_index,
    output logic                 r_e,
    output tlb_pkg::vppn_t       r_vppn,
    output tlb_pkg::ps_t         r_ps,
    output tlb_pkg::asid_t       r_asid,
    output logic                 r_g,
    output tlb_pkg::ppn_t        r_ppn0,
    output tlb_pkg::plv_t        r_plv0,
    output tlb_pkg::mat_t        r_mat0,
    output logic                 r_d0,
    output logic                 r_v0,
    output tlb_pkg::ppn_t        r_ppn1,
    output tlb_pkg::plv_t        r_plv1,
    output tlb_pkg::mat_t        r_mat1,
    output logic                 r_d1,
    output logic                 r_v1
);
    import tlb_pkg::*;

    tlb_vec_t ent_e;
    tlb_vec_t ent_g;
    tlb_vec_t ent_d0;
    tlb_vec_t ent_v0;
    tlb_vec_t ent_d1;
    tlb_vec_t ent_v1;
    vppn_t    ent_vppn [TLB_NUM];
    ps_t      ent_ps   [TLB_NUM];
    asid_t    ent_asid [TLB_NUM];
    ppn_t     ent_ppn0 [TLB_NUM];
    plv_t     ent_plv0 [TLB_NUM];
    mat_t     ent_mat0 [TLB_NUM];
    ppn_t     ent_ppn1 [TLB_NUM];
    plv_t     ent_plv1 [TLB_NUM];
    mat_t     ent_mat1 [TLB_NUM];

    tlb_vec_t hit_vec;
    tlb_vec_t asid_vec;
    tlb_vec_t va_vec;
    tlb_vec_t clear_vec;

    tlb_entry_array u_entry_array (.*);

    // invtlb reuses the search key as its operand
    tlb_match u_match (.*);

    invtlb_decode u_invtlb_decode (.*);

    tlb_search_result u_search_result (.*);

endmodule

// File: dv/tlb_model.svh
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

typedef struct packed {
    logic                e;
    tlb_pkg::vppn_t      vppn;
    tlb_pkg::ps_t        ps;
    tlb_pkg::asid_t      asid;
    logic                g;
    tlb_pkg::ppn_t [1:0] ppn;
    tlb_pkg::plv_t [1:0] plv;
    tlb_pkg::mat_t [1:0] mat;
    logic [1:0]          d;
    logic [1:0]          v;
} entry_t;

typedef struct packed {
    logic              found;
    tlb_pkg::tlb_idx_t index;
    tlb_pkg::ppn_t     ppn;
    tlb_pkg::ps_t      ps;
    tlb_pkg::plv_t     plv;
    tlb_pkg::mat_t     mat;
    logic              d;
    logic              v;
} result_t;

entry_t model_ent [tlb_pkg::TLB_NUM];

function automatic void reset_valid();
    for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
        model_ent[i].e = 1'b0;
    end
endfunction

function automatic void write_entry(tlb_pkg::tlb_idx_t idx, entry_t w);
    model_ent[idx] = w;
endfunction

function automatic entry_t read_entry(tlb_pkg::tlb_idx_t idx);
    return model_ent[idx];
endfunction

function automatic bit va_match(int i, tlb_pkg::vppn_t vppn);
    if (!model_ent[i].e || vppn[18:9] != model_ent[i].vppn[18:9]) begin
        return 1'b0;
    end
    return (model_ent[i].ps == tlb_pkg::PS_2M) || (vppn[8:0] == model_ent[i].vppn[8:0]);
endfunction

function automatic result_t lookup(tlb_pkg::vppn_t vppn, logic va_bit12,
                                   tlb_pkg::asid_t asid);
    result_t r;
    int      odd;
    r = '0;
    for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
        if (va_match(i, vppn) && (model_ent[i].g || model_ent[i].asid == asid)) begin
            odd     = (model_ent[i].ps == tlb_pkg::PS_2M) ? int'(vppn[8]) : int'(va_bit12);
            r.found = 1'b1;
            r.index = tlb_pkg::tlb_idx_t'(i);
            r.ppn   = model_ent[i].ppn[odd];
            r.ps    = model_ent[i].ps;
            r.plv   = model_ent[i].plv[odd];
            r.mat   = model_ent[i].mat[odd];
            r.d     = model_ent[i].d[odd];
            r.v     = model_ent[i].v[odd];
            return r;
        end
    end
    return r;
endfunction

// call before write_entry when both fall on the same edge
function automatic void invalidate(tlb_pkg::invtlb_op_t op, tlb_pkg::vppn_t vppn,
                                   tlb_pkg::asid_t asid);
    bit clr;
    bit a_eq;
    bit v_eq;
    for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
        a_eq = (model_ent[i].asid == asid);
        v_eq = va_match(i, vppn);
        case (op)
            tlb_pkg::INV_ALL0, tlb_pkg::INV_ALL1: clr = 1;
            tlb_pkg::INV_G1:           clr = model_ent[i].g;
            tlb_pkg::INV_G0:           clr = !model_ent[i].g;
            tlb_pkg::INV_G0_ASID:      clr = !model_ent[i].g && a_eq;
            tlb_pkg::INV_G0_ASID_VA:   clr = !model_ent[i].g && a_eq && v_eq;
            tlb_pkg::INV_G_OR_ASID_VA: clr = (model_ent[i].g || a_eq) && v_eq;
            default:                   clr = 0;
        endcase
        if (clr) begin
            model_ent[i].e = 1'b0;
        end
    end
endfunction

`endif

// File: dv/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;
    import tlb_pkg::*;

    `include "tlb_model.svh"

    localparam int SEED     = 57100;
    localparam int N_WRITE  = 64;
    localparam int N_SEARCH = 400;
    localparam int N_ASID   = 64;
    localparam int N_INV    = 200;
    localparam int N_MIXED  = 2000;
    localparam int TOTAL_CYCLES = 5 + TLB_NUM + 32 + 2 * N_WRITE + N_SEARCH
                                + 5 + N_ASID + 2 * N_INV + N_MIXED;
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + 200) * 20;

    logic       clk;
    logic       arst_n;
    vppn_t      s_vppn;
    logic       s_va_bit12;
    asid_t      s_asid;
    logic       s_found;
    tlb_idx_t   s_index;
    ppn_t       s_ppn;
    ps_t        s_ps;
    plv_t       s_plv;
    mat_t       s_mat;
    logic       s_d;
    logic       s_v;
    logic       invtlb_valid;
    invtlb_op_t invtlb_op;
    logic       we;
    tlb_idx_t   w_index;
    logic       w_e;
    vppn_t      w_vppn;
    ps_t        w_ps;
    asid_t      w_asid;
    logic       w_g;
    ppn_t       w_ppn0;
    plv_t       w_plv0;
    mat_t       w_mat0;
    logic       w_d0;
    logic       w_v0;
    ppn_t       w_ppn1;
    plv_t       w_plv1;
    mat_t       w_mat1;
    logic       w_d1;
    logic       w_v1;
    tlb_idx_t   r_index;
    logic       r_e;
    vppn_t      r_vppn;
    ps_t        r_ps;
    asid_t      r_asid;
    logic       r_g;
    ppn_t       r_ppn0;
    plv_t       r_plv0;
    mat_t       r_mat0;
    logic       r_d0;
    logic       r_v0;
    ppn_t       r_ppn1;
    plv_t       r_plv1;
    mat_t       r_mat1;
    logic       r_d1;
    logic       r_v1;

    tlb_vec_t written;
    string    test_name;
    int       checks;
    int       errs;
    int       total_checks;
    int       total_errs;
    int       tests_run;
    int       tests_failed;

    tlb_top dut0 (.*);

    always #10 clk = ~clk;

    task automatic init_inputs();
        clk          = 1'b0;
        arst_n       = 1'b0;
        s_vppn       = '0;
        s_va_bit12   = 1'b0;
        s_asid       = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = '0;
        we           = 1'b0;
        w_index      = '0;
        w_e          = 1'b0;
        w_vppn       = '0;
        w_ps         = PS_4K;
        w_asid       = '0;
        w_g          = 1'b0;
        w_ppn0       = '0;
        w_plv0       = '0;
        w_mat0       = '0;
        w_d0         = 1'b0;
        w_v0         = 1'b0;
        w_ppn1       = '0;
        w_plv1       = '0;
        w_mat1       = '0;
        w_d1         = 1'b0;
        w_v1         = 1'b0;
        r_index      = '0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        checks    = 0;
        errs      = 0;
    endtask

    task automatic end_test();
        $display("test %s finished: %0d checks, %0d errors", test_name, checks, errs);
        tests_run++;
        total_checks += checks;
        total_errs   += errs;
        if (errs != 0) begin
            tests_failed++;
        end
    endtask

    task automatic check_val(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
        checks++;
        if (act !== exp) begin
            $display("Error: test %s, %s expected %0h actual %0h", test_name, what, exp, act);
            errs++;
        end
    endtask

    function automatic entry_t entry_from_inputs();
        entry_t e;
        e.e      = w_e;
        e.vppn   = w_vppn;
        e.ps     = w_ps;
        e.asid   = w_asid;
        e.g      = w_g;
        e.ppn[0] = w_ppn0;
        e.plv[0] = w_plv0;
        e.mat[0] = w_mat0;
        e.d[0]   = w_d0;
        e.v[0]   = w_v0;
        e.ppn[1] = w_ppn1;
        e.plv[1] = w_plv1;
        e.mat[1] = w_mat1;
        e.d[1]   = w_d1;
        e.v[1]   = w_v1;
        return e;
    endfunction

    function automatic logic [127:0] entry_bits(entry_t e);
        return {e.vppn, e.ps, e.asid, e.g,
                e.ppn[0], e.plv[0], e.mat[0], e.d[0], e.v[0],
                e.ppn[1], e.plv[1], e.mat[1], e.d[1], e.v[1]};
    endfunction

    // compares read and search ports with the model state before the next edge
    task automatic check_outputs();
        entry_t  e;
        result_t r;
        e = read_entry(r_index);
        r = lookup(s_vppn, s_va_bit12, s_asid);
        check_val("r_e", e.e, r_e);
        if (written[r_index]) begin
            check_val("read fields", entry_bits(e),
                      {r_vppn, r_ps, r_asid, r_g,
                       r_ppn0, r_plv0, r_mat0, r_d0, r_v0,
                       r_ppn1, r_plv1, r_mat1, r_d1, r_v1});
        end
        check_val("s_found", r.found, s_found);
        if (r.found) begin
            check_val("s_index", r.index, s_index);
            check_val("search fields", {r.ppn, r.ps, r.plv, r.mat, r.d, r.v},
                      {s_ppn, s_ps, s_plv, s_mat, s_d, s_v});
        end
    endtask

    // one clock of checks, then the edge and the same update in the model
    task automatic step();
        #2;
        check_outputs();
        @(posedge clk);
        // invalidate first so a same-edge write wins
        if (invtlb_valid) begin
            invalidate(invtlb_op, s_vppn, s_asid);
        end
        if (we) begin
            write_entry(w_index, entry_from_inputs());
            written[w_index] = 1'b1;
        end
        @(negedge clk);
        we           = 1'b0;
        invtlb_valid = 1'b0;
    endtask

    task automatic expect_search(input logic found, input tlb_idx_t idx);
        #1;
        check_val("s_found", found, s_found);
        if (found) begin
            check_val("s_index", idx, s_index);
        end
    endtask

    // small vppn and asid pools so entries overlap
    task automatic drive_write(input tlb_idx_t idx);
        we      = 1'b1;
        w_index = idx;
        w_e     = ($urandom_range(4) != 0);
        w_vppn  = {10'($urandom_range(3)), 6'd0, 3'($urandom)};
        w_ps    = $urandom_range(1) ? PS_2M : PS_4K;
        w_asid  = asid_t'($urandom_range(3));
        w_g     = ($urandom_range(3) == 0);
        w_ppn0  = ppn_t'($urandom);
        w_plv0  = plv_t'($urandom);
        w_mat0  = mat_t'($urandom);
        w_d0    = 1'($urandom);
        w_v0    = 1'($urandom);
        w_ppn1  = ppn_t'($urandom);
        w_plv1  = plv_t'($urandom);
        w_mat1  = mat_t'($urandom);
        w_d1    = 1'($urandom);
        w_v1    = 1'($urandom);
    endtask

    task automatic random_key();
        s_vppn     = {10'($urandom_range(3)), 6'($urandom), 3'($urandom)};
        s_va_bit12 = 1'($urandom);
        s_asid     = asid_t'($urandom_range(3));
    endtask

    task automatic key_from_entry(input bit same_asid);
        entry_t e;
        e          = read_entry(tlb_idx_t'($urandom_range(TLB_NUM - 1)));
        s_vppn     = e.vppn;
        s_va_bit12 = 1'($urandom);
        s_asid     = same_asid ? e.asid : asid_t'($urandom_range(3));
        // low bits are don't care inside a 2 MB page
        if (e.ps == PS_2M) begin
            s_vppn[8:0] = 9'($urandom);
        end
    endtask

    initial begin
        init_inputs();
        void'($urandom(SEED));
        reset_valid();
        written = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        begin_test("reset_state");
        for (int i = 0; i < TLB_NUM; i++) begin
            r_index = tlb_idx_t'(i);
            random_key();
            step();
        end
        repeat (32) begin
            random_key();
            step();
        end
        end_test();

        begin_test("write_read");
        for (int i = 0; i < N_WRITE; i++) begin
            drive_write(tlb_idx_t'(i < TLB_NUM ? i : $urandom_range(TLB_NUM - 1)));
            step();
            r_index = w_index;
            step();
        end
        end_test();

        begin_test("search");
        repeat (N_SEARCH) begin
            key_from_entry($urandom_range(3) != 0);
            r_index = tlb_idx_t'($urandom_range(TLB_NUM - 1));
            step();
        end
        end_test();

        begin_test("asid_rules");
        // entry 15 private, entry 14 global, both on pages nobody else uses
        drive_write(tlb_idx_t'(15));
        w_e    = 1'b1;
        w_g    = 1'b0;
        w_ps   = PS_4K;
        w_vppn = {10'h3ff, 9'h0};
        w_asid = 10'h2a0;
        step();
        drive_write(tlb_idx_t'(14));
        w_e    = 1'b1;
        w_g    = 1'b1;
        w_ps   = PS_4K;
        w_vppn = {10'h3fe, 9'h0};
        w_asid = 10'h2a1;
        step();
        s_vppn = {10'h3ff, 9'h0};
        s_asid = 10'h2a0;
        expect_search(1'b1, tlb_idx_t'(15));
        step();
        s_asid = 10'h2a1;
        expect_search(1'b0, tlb_idx_t'(0));
        step();
        s_vppn = {10'h3fe, 9'h0};
        s_asid = asid_t'($urandom);
        expect_search(1'b1, tlb_idx_t'(14));
        step();
        repeat (N_ASID) begin
            key_from_entry(1'b1);
            s_asid = s_asid ^ asid_t'($urandom_range(3, 1));
            step();
        end
        end_test();

        begin_test("invalidate");
        repeat (N_INV) begin
            key_from_entry($urandom_range(1) == 1);
            invtlb_valid = 1'b1;
            invtlb_op    = invtlb_op_t'($urandom_range(7));
            r_index      = tlb_idx_t'($urandom_range(TLB_NUM - 1));
            step();
            drive_write(tlb_idx_t'($urandom_range(TLB_NUM - 1)));
            step();
        end
        end_test();

        begin_test("mixed");
        repeat (N_MIXED) begin
            if ($urandom_range(3) != 0) begin
                key_from_entry($urandom_range(3) != 0);
            end else begin
                random_key();
            end
            r_index = tlb_idx_t'($urandom_range(TLB_NUM - 1));
            if ($urandom_range(1) == 1) begin
                drive_write(tlb_idx_t'($urandom_range(TLB_NUM - 1)));
            end
            if ($urandom_range(9) == 0) begin
                invtlb_valid = 1'b1;
                invtlb_op    = invtlb_op_t'($urandom_range(7));
            end
            step();
        end
        end_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: build.f
+incdir+dv
design/tlb_pkg.sv
design/tlb_entry_array.sv
design/tlb_match.sv
design/invtlb_decode.sv
design/tlb_search_result.sv
design/tlb_top.sv
dv/tlb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the TLB testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tlb_tb -o tlb_sim \
    && ./obj_dir/tlb_sim | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1
